/* clkmgr_settings.svh */
/*
 * Clock manager settings.
 * Unit counts, APB widths and the register offsets.
 */

`ifndef CLKMGR_SETTINGS_SVH
`define CLKMGR_SETTINGS_SVH

// Clock counts.
`define CLKMGR_NUM_PERI 4
`define CLKMGR_NUM_TRANS 4

// APB widths.
`define CLKMGR_AW 12
`define CLKMGR_DW 32

// Register offsets.
`define CLKMGR_PERI_EN_OFS 12'h000
`define CLKMGR_HINT_OFS 12'h004
`define CLKMGR_STATUS_OFS 12'h008

`endif

/* clkmgr_pkg.sv */
/*
 * Clock manager clock-side types.
 * Enable vectors and the divider mode.
 */

`include "clkmgr_settings.svh"

package clkmgr_pkg;

  // One bit per software-gated peripheral clock.
  typedef logic [`CLKMGR_NUM_PERI-1:0] peri_en_t;

  // One bit per transactional unit.
  typedef logic [`CLKMGR_NUM_TRANS-1:0] trans_en_t;

  // Divider operating mode.
  typedef enum logic {
    DivNormal,
    DivStepped
  } div_mode_e;

endpackage

/* clkmgr_reg_pkg.sv */
/*
 * Clock manager register-side types.
 */

`include "clkmgr_settings.svh"

package clkmgr_reg_pkg;

  // APB address.
  typedef logic [`CLKMGR_AW-1:0] apb_addr_t;

  // APB read and write data.
  typedef logic [`CLKMGR_DW-1:0] apb_data_t;

endpackage

/* clkmgr_reg.sv */
/*
 * Clock manager APB register block.
 * Peripheral enables, transactional hints and the hint status.
 */

`timescale 1ns/1ps

`include "clkmgr_settings.svh"

module clkmgr_reg
  import clkmgr_pkg::*;
  import clkmgr_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  input  trans_en_t trans_status_i,
  output peri_en_t  peri_sw_en_o,
  output trans_en_t hint_o
);

  logic      access;
  logic      hit_peri;
  logic      hit_hint;
  logic      hit_status;
  logic      hit_any;
  logic      wr_peri;
  logic      wr_hint;
  peri_en_t  peri_sw_en_q;
  trans_en_t hint_q;
  apb_data_t rdata;

  assign access = psel_i & penable_i;

  // Address decode.
  assign hit_peri   = (paddr_i == `CLKMGR_PERI_EN_OFS);
  assign hit_hint   = (paddr_i == `CLKMGR_HINT_OFS);
  assign hit_status = (paddr_i == `CLKMGR_STATUS_OFS);
  assign hit_any    = hit_peri | hit_hint | hit_status;

  assign wr_peri = access & pwrite_i & hit_peri;
  assign wr_hint = access & pwrite_i & hit_hint;

  // Both registers come up with every clock enabled.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      peri_sw_en_q <= '1;
      hint_q       <= '1;
    end else begin
      if (wr_peri) begin
        peri_sw_en_q <= pwdata_i[`CLKMGR_NUM_PERI-1:0];
      end
      if (wr_hint) begin
        hint_q <= pwdata_i[`CLKMGR_NUM_TRANS-1:0];
      end
    end
  end

  // Read data only in a read access cycle, zero otherwise.
  always_comb begin
    rdata = '0;
    if (access && !pwrite_i) begin
      if (hit_peri) begin
        rdata[`CLKMGR_NUM_PERI-1:0] = peri_sw_en_q;
      end else if (hit_hint) begin
        rdata[`CLKMGR_NUM_TRANS-1:0] = hint_q;
      end else if (hit_status) begin
        rdata[`CLKMGR_NUM_TRANS-1:0] = trans_status_i;
      end
    end
  end

  assign prdata_o  = rdata;
  assign pready_o  = 1'b1;
  // Unmapped address, or a write to the read-only status.
  assign pslverr_o = access & (~hit_any | (pwrite_i & hit_status));

  assign peri_sw_en_o = peri_sw_en_q;
  assign hint_o       = hint_q;

  a_err_in_access: assert property (
    @(posedge clk_i) disable iff (rst_i)
    pslverr_o |-> psel_i && penable_i
  );

endmodule

/* clkmgr_trans.sv */
/*
 * Transactional clock gate for one unit.
 * The clock stays on while the unit is busy, whatever the hint says.
 */

`timescale 1ns/1ps

`include "clkmgr_settings.svh"

module clkmgr_trans (
  input  logic clk_i,
  input  logic rst_i,
  input  logic ip_clk_en_i,
  input  logic hint_i,
  input  logic idle_i,
  output logic cg_en_o,
  output logic status_o
);

  logic en_d;
  logic en_q;

  // Off only when software hints off and the unit is idle.
  assign en_d = ip_clk_en_i & (hint_i | ~idle_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en_d;
    end
  end

  assign cg_en_o  = en_q;
  assign status_o = en_q;

  // A busy unit never loses its clock.
  a_busy_keeps_clk: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (ip_clk_en_i && !idle_i) |=> cg_en_o
  );

endmodule

/* clkmgr_div.sv */
/*
 * Clock divider producing div2 and div4 enable pulses.
 * A step-down request halves both ratios.
 */

`timescale 1ns/1ps

`include "clkmgr_settings.svh"

module clkmgr_div
  import clkmgr_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic step_down_i,
  output logic div2_en_o,
  output logic div4_en_o
);

  div_mode_e   mode_q;
  div_mode_e   mode_d;
  logic [1:0]  cnt_q;

  // Free-running phase counter.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

  // Mode follows the sampled request one cycle later.
  always_comb begin
    mode_d = mode_q;
    case (mode_q)
      DivNormal:  if (step_down_i) mode_d = DivStepped;
      DivStepped: if (!step_down_i) mode_d = DivNormal;
      default:    mode_d = DivNormal;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_q <= DivNormal;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign div2_en_o = (mode_q == DivStepped) ? 1'b1 : cnt_q[0];
  assign div4_en_o = (mode_q == DivStepped) ? cnt_q[0] : (cnt_q == 2'd3);

  // The div4 pulse always lands on a div2 pulse.
  a_div4_in_div2: assert property (
    @(posedge clk_i) disable iff (rst_i)
    div4_en_o |-> div2_en_o
  );

endmodule

/* clkmgr.sv */
/*
 * Clock manager top level.
 * Register block, transactional gates and the divider.
 */

`timescale 1ns/1ps

`include "clkmgr_settings.svh"

module clkmgr
  import clkmgr_pkg::*;
  import clkmgr_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  input  logic      ip_clk_en_i,
  input  trans_en_t idle_i,
  input  logic      div_step_down_i,
  output peri_en_t  peri_cg_en_o,
  output trans_en_t trans_cg_en_o,
  output logic      div2_en_o,
  output logic      div4_en_o
);

  peri_en_t  peri_sw_en;
  trans_en_t hint;
  trans_en_t trans_status;

  clkmgr_reg u_reg (
    .clk_i,
    .rst_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .trans_status_i (trans_status),
    .peri_sw_en_o   (peri_sw_en),
    .hint_o         (hint)
  );

  // Peripheral clocks follow the software enable directly.
  assign peri_cg_en_o = {`CLKMGR_NUM_PERI{ip_clk_en_i}} & peri_sw_en;

  for (genvar i = 0; i < `CLKMGR_NUM_TRANS; i++) begin : g_trans
    clkmgr_trans u_trans (
      .clk_i,
      .rst_i,
      .ip_clk_en_i,
      .hint_i   (hint[i]),
      .idle_i   (idle_i[i]),
      .cg_en_o  (trans_cg_en_o[i]),
      .status_o (trans_status[i])
    );
  end

  clkmgr_div u_div (
    .clk_i,
    .rst_i,
    .step_down_i (div_step_down_i),
    .div2_en_o,
    .div4_en_o
  );

endmodule

/* clkmgr_gate_sva.sv */
/*
 * Clock manager gating checker, bound into the top level.
 */

`timescale 1ns/1ps

`include "clkmgr_settings.svh"

module clkmgr_gate_sva
  import clkmgr_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input logic      ip_clk_en_i,
  input trans_en_t idle_i,
  input peri_en_t  peri_sw_en_i,
  input trans_en_t hint_i,
  input peri_en_t  peri_cg_en_i,
  input trans_en_t trans_cg_en_i
);

  a_peri_needs_sw_en: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (peri_cg_en_i & ~peri_sw_en_i) == '0
  );

  for (genvar i = 0; i < `CLKMGR_NUM_TRANS; i++) begin : g_trans_chk
    // Off only after an idle unit was hinted off, or the clock was withdrawn.
    a_trans_off_cause: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (!trans_cg_en_i[i] && !$past(rst_i)) |->
        $past(!hint_i[i] && idle_i[i]) || $past(!ip_clk_en_i)
    );
  end

endmodule

/* clkmgr_bind.sv */
/*
 * Attaches the gating checker to the clock manager top level.
 */

`timescale 1ns/1ps

module clkmgr_bind;

  bind clkmgr clkmgr_gate_sva u_gate_sva (
    .clk_i,
    .rst_i,
    .ip_clk_en_i,
    .idle_i,
    .peri_sw_en_i   (peri_sw_en),
    .hint_i         (hint),
    .peri_cg_en_i   (peri_cg_en_o),
    .trans_cg_en_i  (trans_cg_en_o)
  );

endmodule

/* clkmgr_tb.sv */
/*
 * Clock manager testbench.
 * Drives APB, idles and step-down, and checks every output against a reference model.
 */

`timescale 1ns/1ps

`include "clkmgr_settings.svh"

module clkmgr_tb
  import clkmgr_pkg::*;
  import clkmgr_reg_pkg::*;
;

  localparam int TEST_CYCLES    = 2000;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic      clk;
  logic      rst;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      ip_clk_en;
  trans_en_t idle;
  logic      step_down;
  peri_en_t  peri_cg_en;
  trans_en_t trans_cg_en;
  logic      div2_en;
  logic      div4_en;

  integer    seed = 11688;
  int        cycles = 0;

  // Reference model state.
  peri_en_t  peri_m;
  trans_en_t hint_m;
  trans_en_t trans_m;
  logic [1:0] cnt_m;
  div_mode_e mode_m;

  peri_en_t  exp_peri;
  trans_en_t exp_trans;
  apb_data_t exp_rdata;
  logic      exp_err;
  logic      exp_div2;
  logic      exp_div4;

  clkmgr dut_i (
    .clk_i           (clk),
    .rst_i           (rst),
    .psel_i          (psel),
    .penable_i       (penable),
    .pwrite_i        (pwrite),
    .paddr_i         (paddr),
    .pwdata_i        (pwdata),
    .prdata_o        (prdata),
    .pready_o        (pready),
    .pslverr_o       (pslverr),
    .ip_clk_en_i     (ip_clk_en),
    .idle_i          (idle),
    .div_step_down_i (step_down),
    .peri_cg_en_o    (peri_cg_en),
    .trans_cg_en_o   (trans_cg_en),
    .div2_en_o       (div2_en),
    .div4_en_o       (div4_en)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_peri(input string name, input peri_en_t got, input peri_en_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_trans(input string name, input trans_en_t got, input trans_en_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Div2 in the upper bit, div4 in the lower bit.
  task automatic check_div(input logic got2, input logic got4, input logic exp2,
                           input logic exp4);
    if ({got2, got4} !== {exp2, exp4}) begin
      fail_run($sformatf("** Error: div2_en_o/div4_en_o got 0x%h expected 0x%h",
                         {got2, got4}, {exp2, exp4}));
    end
  endtask

  // Expected outputs for the current cycle, from the model state and the bus inputs.
  function automatic void ref_clkmgr(
    input  logic      ip_en,
    input  logic      sel,
    input  logic      en,
    input  logic      wr,
    input  apb_addr_t addr,
    output peri_en_t  o_peri,
    output trans_en_t o_trans,
    output apb_data_t o_rdata,
    output logic      o_err,
    output logic      o_div2,
    output logic      o_div4
  );
    logic acc;
    logic mapped;
    acc    = sel & en;
    mapped = (addr == `CLKMGR_PERI_EN_OFS) || (addr == `CLKMGR_HINT_OFS) ||
             (addr == `CLKMGR_STATUS_OFS);
    o_peri  = ip_en ? peri_m : '0;
    o_trans = trans_m;
    o_rdata = '0;
    if (acc && !wr) begin
      if (addr == `CLKMGR_PERI_EN_OFS) o_rdata[`CLKMGR_NUM_PERI-1:0] = peri_m;
      if (addr == `CLKMGR_HINT_OFS) o_rdata[`CLKMGR_NUM_TRANS-1:0] = hint_m;
      if (addr == `CLKMGR_STATUS_OFS) o_rdata[`CLKMGR_NUM_TRANS-1:0] = trans_m;
    end
    o_err  = acc && (!mapped || (wr && addr == `CLKMGR_STATUS_OFS));
    // Normal: div2 on odd counts, div4 on count 3. Stepped: div2 always, div4 on odd counts.
    case (mode_m)
      DivStepped: begin
        o_div2 = 1'b1;
        o_div4 = (cnt_m == 2'd1) || (cnt_m == 2'd3);
      end
      default: begin
        o_div2 = (cnt_m == 2'd1) || (cnt_m == 2'd3);
        o_div4 = (cnt_m == 2'd3);
      end
    endcase
  endfunction

  task automatic update_model();
    if (rst) begin
      peri_m  = '1;
      hint_m  = '1;
      trans_m = '0;
      cnt_m   = 2'd0;
      mode_m  = DivNormal;
    end else begin
      for (int i = 0; i < `CLKMGR_NUM_TRANS; i++) begin
        trans_m[i] = ip_clk_en && (hint_m[i] || !idle[i]);
      end
      if (psel && penable && pwrite && paddr == `CLKMGR_PERI_EN_OFS)
        peri_m = pwdata[`CLKMGR_NUM_PERI-1:0];
      if (psel && penable && pwrite && paddr == `CLKMGR_HINT_OFS)
        hint_m = pwdata[`CLKMGR_NUM_TRANS-1:0];
      cnt_m  = cnt_m + 2'd1;
      mode_m = step_down ? DivStepped : DivNormal;
    end
  endtask

  // Outputs are read before this edge's register updates land.
  always @(posedge clk) begin
    if (!rst) begin
      ref_clkmgr(ip_clk_en, psel, penable, pwrite, paddr,
                 exp_peri, exp_trans, exp_rdata, exp_err, exp_div2, exp_div4);
      check_peri("peri_cg_en_o", peri_cg_en, exp_peri);
      check_trans("trans_cg_en_o", trans_cg_en, exp_trans);
      check_data("prdata_o", prdata, exp_rdata);
      check_flag("pslverr_o", pslverr, exp_err);
      check_flag("pready_o", pready, 1'b1);
      check_div(div2_en, div4_en, exp_div2, exp_div4);
    end
    update_model();
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
    end
  end

  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  initial begin
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    ip_clk_en = 1'b0;
    idle      = '1;
    step_down = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset values, then enables rise.
    apb_access(1'b0, `CLKMGR_PERI_EN_OFS, '0);
    apb_access(1'b0, `CLKMGR_HINT_OFS, '0);
    apb_access(1'b0, `CLKMGR_STATUS_OFS, '0);
    ip_clk_en = 1'b1;
    repeat (3) @(negedge clk);
    apb_access(1'b0, `CLKMGR_STATUS_OFS, '0);

    // Peripheral enables.
    repeat (20) begin
      apb_access(1'b1, `CLKMGR_PERI_EN_OFS, $random(seed));
      apb_access(1'b0, `CLKMGR_PERI_EN_OFS, '0);
    end
    ip_clk_en = 1'b0;
    repeat (5) @(negedge clk);
    ip_clk_en = 1'b1;

    // Transactional gating with random hints and idles.
    repeat (40) begin
      idle = $random(seed);
      apb_access(1'b1, `CLKMGR_HINT_OFS, $random(seed));
      idle = $random(seed);
      apb_access(1'b0, `CLKMGR_STATUS_OFS, '0);
    end

    // Rejected accesses, with data that differs from the known register contents.
    apb_access(1'b1, `CLKMGR_PERI_EN_OFS, 32'h0000_0005);
    apb_access(1'b1, `CLKMGR_HINT_OFS, 32'h0000_0005);
    apb_access(1'b1, 12'h00C, 32'hFFFF_FFFA);
    apb_access(1'b0, 12'h100, '0);
    apb_access(1'b1, `CLKMGR_STATUS_OFS, 32'hFFFF_FFFA);
    apb_access(1'b0, `CLKMGR_PERI_EN_OFS, '0);
    apb_access(1'b0, `CLKMGR_HINT_OFS, '0);

    // Divider step-down and release.
    repeat (10) @(negedge clk);
    step_down = 1'b1;
    repeat (20) @(negedge clk);
    step_down = 1'b0;
    repeat (20) @(negedge clk);
    repeat (30) begin
      @(negedge clk);
      step_down = $random(seed);
    end
    step_down = 1'b0;
    repeat (4) @(negedge clk);

    $display("All tests passed");
    $finish;
  end

endmodule

/* list.f */
+incdir+.
clkmgr_pkg.sv
clkmgr_reg_pkg.sv
clkmgr_reg.sv
clkmgr_trans.sv
clkmgr_div.sv
clkmgr.sv
clkmgr_gate_sva.sv
clkmgr_bind.sv
clkmgr_tb.sv

/* Bender.yml */
package:
  name: clkmgr

export_include_dirs:
  - .

sources:
  - files:
      - clkmgr_pkg.sv
      - clkmgr_reg_pkg.sv
      - clkmgr_reg.sv
      - clkmgr_trans.sv
      - clkmgr_div.sv
      - clkmgr.sv
  - target: test
    files:
      - clkmgr_gate_sva.sv
      - clkmgr_bind.sv
      - clkmgr_tb.sv
